// ==== source/clause_params.svh ====
`ifndef CLAUSE_PARAMS_SVH
`define CLAUSE_PARAMS_SVH

// Clauses held by one bin.
`define NUM_CLAUSES_A_BIN 4

// Variables local to one bin.
`define NUM_VARS_A_BIN 8

// Width of a clause length field.
`define WIDTH_C_LEN 5

`endif

// ==== source/sat_var_pkg.sv ====
`include "clause_params.svh"

package sat_var_pkg;

    // State of one variable as seen by the base.
    typedef logic [2:0] var_state_t;

    localparam var_state_t VAR_FREE  = 3'b000;
    localparam var_state_t VAR_TRUE  = 3'b001;
    localparam var_state_t VAR_FALSE = 3'b010;
    // Both polarities implied in the same round.
    localparam var_state_t VAR_BOTH  = 3'b011;

    // States of all bin variables, variable 0 in the low slot.
    typedef logic [3*`NUM_VARS_A_BIN-1:0] var_word_t;

    // Literal code of one variable inside a clause.
    typedef logic [1:0] lit_t;

    localparam lit_t LIT_ABSENT = 2'b00;
    localparam lit_t LIT_POS    = 2'b01;
    localparam lit_t LIT_NEG    = 2'b10;

    typedef enum logic [1:0] {
        CLS_ABSENT,
        CLS_TRUE,
        CLS_FALSE,
        CLS_FREE
    } lit_class_t;

endpackage

// ==== source/clause_pkg.sv ====
`include "clause_params.svh"

package clause_pkg;

    // Number of literals in a clause.
    typedef logic [`WIDTH_C_LEN-1:0] clause_len_t;

    // Two bits per bin variable, variable 0 in the low bits.
    typedef logic [2*`NUM_VARS_A_BIN-1:0] clause_lits_t;

    typedef enum logic [1:0] {
        CL_OPEN,
        CL_SAT,
        CL_UNIT,
        CL_CONFLICT
    } clause_status_t;

    // Result stage of the bin.
    typedef enum logic [1:0] {
        RES_IDLE,
        RES_MERGE,
        RES_HOLD
    } result_state_t;

endpackage

// ==== source/lit_decode.sv ====
`timescale 1ns/10ps
`include "clause_params.svh"

module lit_decode (
    input  clause_pkg::clause_lits_t    lits_i,
    input  sat_var_pkg::var_word_t      var_state_i,
    output logic [`NUM_VARS_A_BIN-1:0]  true_mask_o,
    output logic [`NUM_VARS_A_BIN-1:0]  false_mask_o,
    output logic [`NUM_VARS_A_BIN-1:0]  free_mask_o
);

    function automatic sat_var_pkg::lit_class_t classify(
        input sat_var_pkg::lit_t       lit,
        input sat_var_pkg::var_state_t state
    );
        classify = sat_var_pkg::CLS_ABSENT;
        if (lit == sat_var_pkg::LIT_POS || lit == sat_var_pkg::LIT_NEG) begin
            case (state)
                sat_var_pkg::VAR_FREE:  classify = sat_var_pkg::CLS_FREE;
                sat_var_pkg::VAR_TRUE:  classify = (lit == sat_var_pkg::LIT_POS) ?
                                                   sat_var_pkg::CLS_TRUE :
                                                   sat_var_pkg::CLS_FALSE;
                sat_var_pkg::VAR_FALSE: classify = (lit == sat_var_pkg::LIT_NEG) ?
                                                   sat_var_pkg::CLS_TRUE :
                                                   sat_var_pkg::CLS_FALSE;
                default:                classify = sat_var_pkg::CLS_ABSENT;
            endcase
        end
    endfunction

    always_comb begin : decode
        sat_var_pkg::lit_class_t cls;
        for (int i = 0; i < `NUM_VARS_A_BIN; i++) begin
            cls = classify(lits_i[2*i +: 2], var_state_i[3*i +: 3]);
            true_mask_o[i]  = (cls == sat_var_pkg::CLS_TRUE);
            false_mask_o[i] = (cls == sat_var_pkg::CLS_FALSE);
            free_mask_o[i]  = (cls == sat_var_pkg::CLS_FREE);
        end
    end

endmodule

// ==== source/clause_eval.sv ====
`timescale 1ns/10ps
`include "clause_params.svh"

module clause_eval (
    input  clause_pkg::clause_lits_t    lits_i,
    input  clause_pkg::clause_len_t     len_i,
    input  logic [`NUM_VARS_A_BIN-1:0]  true_mask_i,
    input  logic [`NUM_VARS_A_BIN-1:0]  false_mask_i,
    input  logic [`NUM_VARS_A_BIN-1:0]  free_mask_i,
    output clause_pkg::clause_status_t  status_o,
    output sat_var_pkg::var_word_t      impl_word_o
);

    clause_pkg::clause_len_t true_cnt;
    clause_pkg::clause_len_t false_cnt;
    clause_pkg::clause_len_t free_cnt;

    always_comb begin : count
        true_cnt  = '0;
        false_cnt = '0;
        free_cnt  = '0;
        for (int i = 0; i < `NUM_VARS_A_BIN; i++) begin
            true_cnt  = true_cnt + clause_pkg::clause_len_t'(true_mask_i[i]);
            false_cnt = false_cnt + clause_pkg::clause_len_t'(false_mask_i[i]);
            free_cnt  = free_cnt + clause_pkg::clause_len_t'(free_mask_i[i]);
        end
    end

    // An empty clause slot is never unit or conflicting.
    always_comb begin : classify
        if (true_cnt != '0) begin
            status_o = clause_pkg::CL_SAT;
        end else if (len_i == '0) begin
            status_o = clause_pkg::CL_OPEN;
        end else if (false_cnt == len_i) begin
            status_o = clause_pkg::CL_CONFLICT;
        end else if (false_cnt == len_i - clause_pkg::clause_len_t'(1) && free_cnt == 1) begin
            status_o = clause_pkg::CL_UNIT;
        end else begin
            status_o = clause_pkg::CL_OPEN;
        end
    end

    // The single free literal is forced to the value that satisfies it.
    always_comb begin : implication
        impl_word_o = '0;
        for (int i = 0; i < `NUM_VARS_A_BIN; i++) begin
            if (status_o == clause_pkg::CL_UNIT && free_mask_i[i]) begin
                impl_word_o[3*i +: 3] = (lits_i[2*i +: 2] == sat_var_pkg::LIT_POS) ?
                                        sat_var_pkg::VAR_TRUE : sat_var_pkg::VAR_FALSE;
            end
        end
    end

endmodule

// ==== source/clause_cell.sv ====
`timescale 1ns/10ps
`include "clause_params.svh"

module clause_cell (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       wr_i,
    input  sat_var_pkg::var_word_t     var_value_frombase_i,
    input  clause_pkg::clause_len_t    clause_len_i,
    input  logic                       apply_impl_i,
    input  logic                       apply_bkt_i,
    output sat_var_pkg::var_word_t     var_value_tobase_o,
    output clause_pkg::clause_len_t    clause_len_o,
    output logic                       conflict_o
);

    typedef struct packed {
        clause_pkg::clause_lits_t lits;
        clause_pkg::clause_len_t  len;
    } clause_store_t;

    typedef struct packed {
        sat_var_pkg::var_word_t impl;
        logic                   conflict;
    } cell_result_t;

    clause_store_t              store_d;
    clause_store_t              store_q;
    cell_result_t               result_q;
    logic [`NUM_VARS_A_BIN-1:0] true_mask;
    logic [`NUM_VARS_A_BIN-1:0] false_mask;
    logic [`NUM_VARS_A_BIN-1:0] free_mask;
    clause_pkg::clause_status_t status;
    sat_var_pkg::var_word_t     impl_word;

    // During a write each state slot carries the literal code in its low bits.
    always_comb begin : capture
        store_d.len = clause_len_i;
        for (int i = 0; i < `NUM_VARS_A_BIN; i++) begin
            store_d.lits[2*i +: 2] = var_value_frombase_i[3*i +: 2];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            store_q <= '0;
        end else if (wr_i) begin
            store_q <= store_d;
        end
    end

    lit_decode i_lit_decode (
        .lits_i       (store_q.lits),
        .var_state_i  (var_value_frombase_i),
        .true_mask_o  (true_mask),
        .false_mask_o (false_mask),
        .free_mask_o  (free_mask)
    );

    clause_eval i_clause_eval (
        .lits_i       (store_q.lits),
        .len_i        (store_q.len),
        .true_mask_i  (true_mask),
        .false_mask_i (false_mask),
        .free_mask_i  (free_mask),
        .status_o     (status),
        .impl_word_o  (impl_word)
    );

    // A backtrack drops the result but keeps the stored clause.
    always_ff @(posedge clk) begin
        if (!rst_n_i || apply_bkt_i) begin
            result_q <= '0;
        end else if (apply_impl_i) begin
            result_q.impl     <= impl_word;
            result_q.conflict <= (status == clause_pkg::CL_CONFLICT);
        end
    end

    assign var_value_tobase_o = result_q.impl;
    assign conflict_o         = result_q.conflict;
    assign clause_len_o       = store_q.len;

endmodule

// ==== source/clause4.sv ====
`timescale 1ns/10ps
`include "clause_params.svh"

module clause4 (
    input  logic                                               clk,
    input  logic                                               rst_n_i,
    input  logic [`NUM_CLAUSES_A_BIN-1:0]                      wr_i,
    input  sat_var_pkg::var_word_t                             var_value_frombase_i,
    input  clause_pkg::clause_len_t                            clause_len_i,
    input  logic                                               apply_impl_i,
    input  logic                                               apply_bkt_i,
    output sat_var_pkg::var_word_t                             var_value_tobase_o,
    output clause_pkg::clause_len_t [`NUM_CLAUSES_A_BIN-1:0]   clause_len_o,
    output logic [`NUM_CLAUSES_A_BIN-1:0]                      clause_conflict_o
);

    sat_var_pkg::var_word_t impl_words [`NUM_CLAUSES_A_BIN];

    // Cell k owns write strobe bit k and length field k.
    for (genvar k = 0; k < `NUM_CLAUSES_A_BIN; k++) begin : g_cell
        clause_cell i_clause_cell (
            .clk                  (clk),
            .rst_n_i              (rst_n_i),
            .wr_i                 (wr_i[k]),
            .var_value_frombase_i (var_value_frombase_i),
            .clause_len_i         (clause_len_i),
            .apply_impl_i         (apply_impl_i),
            .apply_bkt_i          (apply_bkt_i),
            .var_value_tobase_o   (impl_words[k]),
            .clause_len_o         (clause_len_o[k]),
            .conflict_o           (clause_conflict_o[k])
        );
    end

    // Opposite implications on one variable overlap to 011 here.
    always_comb begin : merge
        var_value_tobase_o = '0;
        for (int k = 0; k < `NUM_CLAUSES_A_BIN; k++) begin
            var_value_tobase_o = var_value_tobase_o | impl_words[k];
        end
    end

endmodule

// ==== source/bin_result.sv ====
`timescale 1ns/10ps
`include "clause_params.svh"

module bin_result (
    input  logic                               clk,
    input  logic                               rst_n_i,
    input  logic                               apply_impl_i,
    input  logic                               apply_bkt_i,
    input  sat_var_pkg::var_word_t             merged_word_i,
    input  logic [`NUM_CLAUSES_A_BIN-1:0]      clause_conflict_i,
    output sat_var_pkg::var_word_t             var_value_tobase_o,
    output logic                               impl_valid_o,
    output logic                               conflict_o
);

    clause_pkg::result_state_t state_q;
    sat_var_pkg::var_word_t    word_q;
    logic                      valid_q;
    logic                      conflict_q;
    logic                      both_implied;

    always_comb begin : opposing
        both_implied = 1'b0;
        for (int i = 0; i < `NUM_VARS_A_BIN; i++) begin
            if (merged_word_i[3*i +: 3] == sat_var_pkg::VAR_BOTH) begin
                both_implied = 1'b1;
            end
        end
    end

    // The cells register on the apply edge, so the merge is taken one edge later.
    always_ff @(posedge clk) begin
        if (!rst_n_i || apply_bkt_i) begin
            state_q    <= clause_pkg::RES_IDLE;
            word_q     <= '0;
            valid_q    <= 1'b0;
            conflict_q <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            case (state_q)
                clause_pkg::RES_MERGE: begin
                    word_q     <= merged_word_i;
                    conflict_q <= (|clause_conflict_i) || both_implied;
                    valid_q    <= 1'b1;
                    state_q    <= apply_impl_i ? clause_pkg::RES_MERGE : clause_pkg::RES_HOLD;
                end
                default: begin
                    if (apply_impl_i) begin
                        state_q <= clause_pkg::RES_MERGE;
                    end
                end
            endcase
        end
    end

    assign var_value_tobase_o = word_q;
    assign impl_valid_o       = valid_q;
    assign conflict_o         = conflict_q;

endmodule

// ==== source/clause_bin.sv ====
`timescale 1ns/10ps
`include "clause_params.svh"

module clause_bin (
    input  logic                                              clk,
    input  logic                                              rst_n_i,
    input  logic [`NUM_CLAUSES_A_BIN-1:0]                     wr_i,
    input  sat_var_pkg::var_word_t                            var_value_frombase_i,
    input  clause_pkg::clause_len_t                           clause_len_i,
    input  logic                                              apply_impl_i,
    input  logic                                              apply_bkt_i,
    output sat_var_pkg::var_word_t                            var_value_tobase_o,
    output clause_pkg::clause_len_t [`NUM_CLAUSES_A_BIN-1:0]  clause_len_o,
    output logic                                              impl_valid_o,
    output logic                                              conflict_o
);

    sat_var_pkg::var_word_t          var_value_tobase;
    logic [`NUM_CLAUSES_A_BIN-1:0]   clause_conflict;

    clause4 i_clause4 (
        .clk                  (clk),
        .rst_n_i              (rst_n_i),
        .wr_i                 (wr_i),
        .var_value_frombase_i (var_value_frombase_i),
        .clause_len_i         (clause_len_i),
        .apply_impl_i         (apply_impl_i),
        .apply_bkt_i          (apply_bkt_i),
        .var_value_tobase_o   (var_value_tobase),
        .clause_len_o         (clause_len_o),
        .clause_conflict_o    (clause_conflict)
    );

    bin_result i_bin_result (
        .clk                (clk),
        .rst_n_i            (rst_n_i),
        .apply_impl_i       (apply_impl_i),
        .apply_bkt_i        (apply_bkt_i),
        .merged_word_i      (var_value_tobase),
        .clause_conflict_i  (clause_conflict),
        .var_value_tobase_o (var_value_tobase_o),
        .impl_valid_o       (impl_valid_o),
        .conflict_o         (conflict_o)
    );

endmodule

// ==== tests/clause_bin_tb.sv ====
`timescale 1ns/10ps
`include "clause_params.svh"

module clause_bin_tb;

    typedef struct packed {
        logic [7:0]  kind;
        logic [31:0] f0;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
    } record_t;

    logic                                              clk;
    logic                                              rst_n_i;
    logic [`NUM_CLAUSES_A_BIN-1:0]                     wr_i;
    sat_var_pkg::var_word_t                            var_value_frombase_i;
    clause_pkg::clause_len_t                           clause_len_i;
    logic                                              apply_impl_i;
    logic                                              apply_bkt_i;
    sat_var_pkg::var_word_t                            var_value_tobase_o;
    clause_pkg::clause_len_t [`NUM_CLAUSES_A_BIN-1:0]  clause_len_o;
    logic                                              impl_valid_o;
    logic                                              conflict_o;

    record_t recs[$];
    int      cycles = 0;
    int      cycle_limit = 20;
    logic    in_apply = 1'b0;

    clause_bin i_clause_bin (
        .clk                  (clk),
        .rst_n_i              (rst_n_i),
        .wr_i                 (wr_i),
        .var_value_frombase_i (var_value_frombase_i),
        .clause_len_i         (clause_len_i),
        .apply_impl_i         (apply_impl_i),
        .apply_bkt_i          (apply_bkt_i),
        .var_value_tobase_o   (var_value_tobase_o),
        .clause_len_o         (clause_len_o),
        .impl_valid_o         (impl_valid_o),
        .conflict_o           (conflict_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input sat_var_pkg::var_word_t got,
                              input sat_var_pkg::var_word_t exp);
        if (got !== exp) begin
            report_failure($sformatf("FAIL t=%0t %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_len(input string name, input clause_pkg::clause_len_t got,
                             input clause_pkg::clause_len_t exp);
        if (got !== exp) begin
            report_failure($sformatf("FAIL t=%0t %s got %0d expected %0d", $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("FAIL t=%0t %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    // A literal code travels in the low two bits of its variable's state slot.
    function automatic sat_var_pkg::var_word_t expand_lits(input clause_pkg::clause_lits_t lits);
        sat_var_pkg::var_word_t word;
        word = '0;
        for (int i = 0; i < `NUM_VARS_A_BIN; i++) begin
            word[3*i +: 2] = lits[2*i +: 2];
        end
        return word;
    endfunction

    task automatic load_patterns();
        int               fd;
        int               code;
        logic [7:0]       kind;
        logic [31:0]      f0;
        logic [31:0]      f1;
        logic [31:0]      f2;
        logic [31:0]      f3;
        logic [8*128-1:0] rest;
        fd = $fopen("tests/clause_bin_patterns.txt", "r");
        if (fd == 0) begin
            report_failure("could not open the pattern file tests/clause_bin_patterns.txt");
        end
        while ($fscanf(fd, "%s", kind) == 1) begin
            f0 = '0;
            f1 = '0;
            f2 = '0;
            f3 = '0;
            case (kind)
                "#": code = $fgets(rest, fd);
                "W": code = $fscanf(fd, "%d %d %h", f0, f1, f2);
                "A": code = $fscanf(fd, "%h %h %h", f0, f1, f2);
                "L": code = $fscanf(fd, "%d %d %d %d", f0, f1, f2, f3);
                "B": code = 0;
                default: report_failure("the pattern file holds an unknown record kind");
            endcase
            if (((kind == "W" || kind == "A") && code != 3) || (kind == "L" && code != 4)) begin
                report_failure("a record in the pattern file has missing fields");
            end
            if (kind != "#") begin
                recs.push_back({kind, f0, f1, f2, f3});
            end
        end
        $fclose(fd);
    endtask

    task automatic write_clause(input logic [1:0] idx, input clause_pkg::clause_len_t len,
                                input clause_pkg::clause_lits_t lits);
        @(posedge clk);
        wr_i                 <= '0;
        wr_i[idx]            <= 1'b1;
        var_value_frombase_i <= expand_lits(lits);
        clause_len_i         <= len;
        @(posedge clk);
        wr_i <= '0;
    endtask

    task automatic apply_states(input sat_var_pkg::var_word_t states,
                                input sat_var_pkg::var_word_t exp_word, input logic exp_conflict);
        logic seen;
        seen = 1'b0;
        in_apply = 1'b1;
        @(posedge clk);
        var_value_frombase_i <= states;
        apply_impl_i         <= 1'b1;
        @(posedge clk);
        apply_impl_i <= 1'b0;
        for (int waited = 0; waited < 2 && !seen; waited++) begin
            @(negedge clk);
            seen = impl_valid_o;
        end
        if (!seen) begin
            report_failure("impl_valid_o did not pulse within two edges of the apply pulse");
        end
        check_word("var_value_tobase_o", var_value_tobase_o, exp_word);
        check_bit("conflict_o", conflict_o, exp_conflict);
        @(negedge clk);
        if (impl_valid_o) begin
            report_failure("impl_valid_o stayed high for more than one cycle");
        end
        in_apply = 1'b0;
    endtask

    task automatic backtrack();
        @(posedge clk);
        apply_bkt_i <= 1'b1;
        @(posedge clk);
        apply_bkt_i <= 1'b0;
        @(negedge clk);
        check_word("var_value_tobase_o", var_value_tobase_o, '0);
        check_bit("conflict_o", conflict_o, 1'b0);
    endtask

    task automatic check_lengths(input record_t rec);
        @(negedge clk);
        check_len("clause_len_o[0]", clause_len_o[0], rec.f0[4:0]);
        check_len("clause_len_o[1]", clause_len_o[1], rec.f1[4:0]);
        check_len("clause_len_o[2]", clause_len_o[2], rec.f2[4:0]);
        check_len("clause_len_o[3]", clause_len_o[3], rec.f3[4:0]);
    endtask

    // A valid pulse may only follow an apply.
    always @(negedge clk) begin
        if (rst_n_i && impl_valid_o && !in_apply) begin
            report_failure("impl_valid_o pulsed without an apply");
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            report_failure($sformatf("timeout after %0d clock cycles", cycles));
        end
    end

    initial begin : stimulus
        record_t rec;
        rst_n_i              = 1'b0;
        wr_i                 = '0;
        var_value_frombase_i = '0;
        clause_len_i         = '0;
        apply_impl_i         = 1'b0;
        apply_bkt_i          = 1'b0;
        load_patterns();
        cycle_limit = 10 * recs.size() + 20;
        repeat (4) @(posedge clk);
        rst_n_i <= 1'b1;
        @(negedge clk);
        check_word("var_value_tobase_o", var_value_tobase_o, '0);
        check_bit("conflict_o", conflict_o, 1'b0);
        foreach (recs[i]) begin
            rec = recs[i];
            case (rec.kind)
                "W": write_clause(rec.f0[1:0], rec.f1[4:0], rec.f2[15:0]);
                "A": apply_states(rec.f0[23:0], rec.f1[23:0], rec.f2[0]);
                "L": check_lengths(rec);
                default: backtrack();
            endcase
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+source
source/sat_var_pkg.sv
source/clause_pkg.sv
source/lit_decode.sv
source/clause_eval.sv
source/clause_cell.sv
source/clause4.sv
source/bin_result.sv
source/clause_bin.sv
tests/clause_bin_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timescale 1ns/10ps
TOP       := clause_bin_tb
FILELIST  := vlog.f

OBJ_DIR := obj_dir
BIN     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard source/*.sv source/*.svh tests/*.sv)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== tests/clause_bin_patterns.txt ====
# W clause len lits_hex | A states_hex expected_word_hex expected_conflict
# L len0 len1 len2 len3 | B backtrack
L 0 0 0 0
A 000000 000000 0
W 0 3 0019
L 3 0 0 0
W 1 2 0180
W 2 5 9400
W 3 2 0420
L 3 2 5 2
W 2 3 9400
L 3 2 3 2
A 00020a 001040 0
A 01020a 0010c0 1
A 00a201 000000 1
B
A 090000 400080 0
B
A 00020a 001040 0
